/* filelist.f */
axis_pkg.sv
axis_upsizer.sv
axis_frame_mux.sv
axis_merge_top.sv
tb_axis_merge_assert.sv
tb_axis_merge.sv

/* tb_axis_merge.sv */
`default_nettype none

module tb_axis_merge import axis_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_LEN = 32;
  // About 900 bytes over all tests at most, four cycles per byte under back-pressure, plus margin
  localparam int MAX_BYTES = 900;
  localparam int TIMEOUT_CYCLES = MAX_BYTES * 4 + 400;
  // Words still in flight once the drivers are done leave well within this
  localparam int DRAIN_CYCLES = 400;

  logic         clk;
  logic         rst;
  narrow_beat_t in_beat_0;
  logic         in_valid_0;
  logic         in_ready_0;
  narrow_beat_t in_beat_1;
  logic         in_valid_1;
  logic         in_ready_1;
  wide_beat_t   out_beat;
  lane_id_t     out_src;
  logic         out_valid;
  logic         out_ready;

  wide_beat_t exp_q0[$];  // Expected words of lane 0 in order
  wide_beat_t exp_q1[$];
  lane_id_t   frame_srcs[$];
  logic       in_frame;
  lane_id_t   cur_src;
  logic       random_ready;
  int         errors;
  int         tests_passed;
  int         tests_failed;
  int         cycle_count;

  axis_merge_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .in_beat_0  (in_beat_0),
    .in_valid_0 (in_valid_0),
    .in_ready_0 (in_ready_0),
    .in_beat_1  (in_beat_1),
    .in_valid_1 (in_valid_1),
    .in_ready_1 (in_ready_1),
    .out_beat   (out_beat),
    .out_src    (out_src),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the output never drained", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  // Back-pressure source, out_ready stays high unless random mode is on
  always @(posedge clk) begin
    #1;
    if (random_ready) begin
      out_ready = ($urandom % 2) == 1;
    end else begin
      out_ready = 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("mismatch at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    errors++;
  endtask

  function automatic word_t keep_mask(input keep_t keep);
    word_t m;
    m = '0;
    for (int i = 0; i < WORD_BYTES; i++) begin
      if (keep[i]) begin
        m[8*i +: 8] = 8'hff;
      end
    end
    return m;
  endfunction

  // Checks each transferred word against the queue of the lane named by out_src
  always @(negedge clk) begin
    wide_beat_t expected;
    if (rst) begin
      in_frame = 1'b0;
    end else if (out_valid && out_ready) begin
      if (in_frame) begin
        check_value("out_src", cur_src, out_src);
      end else begin
        frame_srcs.push_back(out_src);
      end
      cur_src  = out_src;
      in_frame = !out_beat.last;
      if ((out_src == 1'b0 && exp_q0.size() == 0) || (out_src == 1'b1 && exp_q1.size() == 0)) begin
        report_error($sformatf("word on lane %0d that was never sent", out_src));
      end else begin
        expected = out_src ? exp_q1.pop_front() : exp_q0.pop_front();
        check_value("out_beat.keep", expected.keep, out_beat.keep);
        check_value("out_beat.data", expected.data & keep_mask(expected.keep),
                    out_beat.data & keep_mask(expected.keep));
        check_value("out_beat.last", expected.last, out_beat.last);
        check_value("out_beat.user", expected.user, out_beat.user);
      end
    end
  end

  task automatic drive_lane(input int lane, input narrow_beat_t beat, input logic valid);
    if (lane == 0) begin
      in_beat_0  = beat;
      in_valid_0 = valid;
    end else begin
      in_beat_1  = beat;
      in_valid_1 = valid;
    end
  endtask

  // Error index below zero means a clean frame, otherwise that byte and the last one carry user
  task automatic send_frame(input int lane, input int len, input int err_idx, input bit gaps);
    byte_t        data [MAX_LEN];
    logic         flags [MAX_LEN];
    wide_beat_t   w;
    narrow_beat_t b;
    int           pos;
    bit           fire;
    for (int i = 0; i < len; i++) begin
      data[i]  = byte_t'($urandom);
      flags[i] = (err_idx >= 0) && (i == err_idx || i == len - 1);
    end
    w = '0;
    for (int i = 0; i < len; i++) begin
      pos = i % WORD_BYTES;
      w.data[8*pos +: 8] = data[i];
      w.keep[pos] = 1'b1;
      w.user = w.user | flags[i];
      if (pos == WORD_BYTES - 1 || i == len - 1) begin
        w.last = (i == len - 1);
        if (lane == 0) begin
          exp_q0.push_back(w);
        end else begin
          exp_q1.push_back(w);
        end
        w = '0;
      end
    end
    for (int i = 0; i < len; i++) begin
      if (gaps && ($urandom % 4) == 0) begin
        drive_lane(lane, '0, 1'b0);
        repeat (1 + $urandom % 3) begin
          @(posedge clk);
          #1;
        end
      end
      b.data = data[i];
      b.last = (i == len - 1);
      b.user = flags[i];
      drive_lane(lane, b, 1'b1);
      do begin
        fire = (lane == 0) ? in_ready_0 : in_ready_1;  // Registered, stable until the next edge
        @(posedge clk);
        #1;
      end while (!fire);
    end
    drive_lane(lane, '0, 1'b0);
  endtask

  // A word that never comes out leaves its lane's queue non-empty
  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      #1;
      waited++;
    end
    check_value("exp_q0 size", 0, exp_q0.size());
    check_value("exp_q1 size", 0, exp_q1.size());
    exp_q0.delete();
    exp_q1.delete();
    repeat (2) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset();
    int e;
    e = errors;
    rst = 1'b1;
    repeat (8) begin
      @(posedge clk);
      #1;
      check_value("in_ready_0", 1'b0, in_ready_0);
      check_value("in_ready_1", 1'b0, in_ready_1);
      check_value("out_valid", 1'b0, out_valid);
    end
    rst = 1'b0;
    finish_test("reset", e);
  endtask

  task automatic test_full_words();
    int e;
    e = errors;
    send_frame(0, 8, -1, 1'b0);
    send_frame(0, 16, -1, 1'b1);
    send_frame(1, 12, -1, 1'b0);
    send_frame(1, 4, -1, 1'b1);
    wait_drained();
    finish_test("full_words", e);
  endtask

  task automatic test_short_words();
    int e;
    int lens [5];
    e = errors;
    lens = '{1, 2, 3, 5, 7};
    for (int i = 0; i < 5; i++) begin
      send_frame(0, lens[i], -1, 1'b0);
      send_frame(1, lens[i], -1, 1'b0);
    end
    wait_drained();
    finish_test("short_words", e);
  endtask

  task automatic test_error_flag();
    int e;
    e = errors;
    send_frame(0, 10, 2, 1'b0);
    send_frame(1, 9, 8, 1'b0);
    send_frame(0, 6, 4, 1'b1);
    send_frame(1, 3, 0, 1'b0);
    wait_drained();
    finish_test("error_flag", e);
  endtask

  // Long frames on both lanes keep the idle lane's next frame pending at each frame boundary
  task automatic test_both_lanes();
    int e;
    int lens [4];
    e = errors;
    lens = '{16, 21, 18, 24};
    frame_srcs.delete();
    fork
      for (int i = 0; i < 4; i++) send_frame(0, lens[i], -1, 1'b0);
      for (int i = 0; i < 4; i++) send_frame(1, lens[i], -1, 1'b0);
    join
    wait_drained();
    check_value("frame count", 8, frame_srcs.size());
    for (int i = 1; i < frame_srcs.size(); i++) begin
      if (frame_srcs[i] == frame_srcs[i - 1]) begin
        report_error($sformatf("grant did not alternate, frames %0d and %0d both from lane %0d",
                               i - 1, i, frame_srcs[i]));
      end
    end
    finish_test("both_lanes", e);
  endtask

  task automatic test_random_ready();
    int e;
    e = errors;
    random_ready = 1'b1;
    fork
      for (int i = 0; i < 6; i++) begin
        send_frame(0, 1 + int'($urandom % 24), int'($urandom % 32) - 8, 1'b1);
      end
      for (int i = 0; i < 6; i++) begin
        send_frame(1, 1 + int'($urandom % 24), int'($urandom % 32) - 8, 1'b1);
      end
    join
    wait_drained();
    random_ready = 1'b0;
    repeat (20) begin
      @(posedge clk);
      #1;
      check_value("out_valid", 1'b0, out_valid);  // Anything left now would be a duplicate
    end
    finish_test("random_ready", e);
  endtask

  initial begin
    void'($urandom(32'h9836e52e));
    rst          = 1'b1;
    in_beat_0    = '0;
    in_valid_0   = 1'b0;
    in_beat_1    = '0;
    in_valid_1   = 1'b0;
    out_ready    = 1'b1;
    random_ready = 1'b0;
    in_frame     = 1'b0;
    cur_src      = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count  = 0;

    test_reset();
    test_full_words();
    test_short_words();
    test_error_flag();
    test_both_lanes();
    test_random_ready();

    $display("Summary: %0d passed, %0d failed, %0d errors, %0d assertion failures",
             tests_passed, tests_failed, errors, dut_i.assert_i.failures);
    if (errors == 0 && dut_i.assert_i.failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_axis_merge_assert.sv */
`default_nettype none

module axis_merge_assert import axis_pkg::*; (
  input wire logic       clk,
  input wire logic       rst,
  input wire wide_beat_t out_beat,
  input wire lane_id_t   out_src,
  input wire logic       out_valid,
  input wire logic       out_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  logic     mid_frame;  // First word of a frame is out, its last word is still to come
  lane_id_t frame_src;
  int       failures = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      mid_frame <= 1'b0;
      frame_src <= '0;
    end else if (out_valid && out_ready) begin
      mid_frame <= !out_beat.last;
      frame_src <= out_src;
    end
  end

  hold_while_stalled: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat) && $stable(out_src)
  ) else begin
    $error("Output word changed or was dropped while out_ready was low");
    failures++;
  end

  src_within_frame: assert property (
    @(posedge clk) disable iff (rst)
    mid_frame && out_valid |-> out_src == frame_src
  ) else begin
    $error("out_src changed before the frame's last word");
    failures++;
  end

  // Synchronous reset clears out_valid one edge after rst is seen
  valid_low_in_reset: assert property (
    @(posedge clk) rst |=> !out_valid
  ) else begin
    $error("out_valid high during reset");
    failures++;
  end

endmodule

bind axis_merge_top axis_merge_assert assert_i (
  .clk       (clk),
  .rst       (rst),
  .out_beat  (out_beat),
  .out_src   (out_src),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

`default_nettype wire

/* axis_merge_top.sv */
`default_nettype none

module axis_merge_top import axis_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire narrow_beat_t in_beat_0,
  input  wire logic         in_valid_0,
  output logic              in_ready_0,
  input  wire narrow_beat_t in_beat_1,
  input  wire logic         in_valid_1,
  output logic              in_ready_1,
  output wide_beat_t        out_beat,
  output lane_id_t          out_src,
  output logic              out_valid,
  input  wire logic         out_ready
);

  wide_beat_t up_beat_0;
  logic       up_valid_0;
  logic       up_ready_0;
  wide_beat_t up_beat_1;
  logic       up_valid_1;
  logic       up_ready_1;

  // Lane 0 byte stream to words
  axis_upsizer up0_i (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat_0),
    .in_valid  (in_valid_0),
    .in_ready  (in_ready_0),
    .out_beat  (up_beat_0),
    .out_valid (up_valid_0),
    .out_ready (up_ready_0)
  );

  axis_upsizer up1_i (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat_1),
    .in_valid  (in_valid_1),
    .in_ready  (in_ready_1),
    .out_beat  (up_beat_1),
    .out_valid (up_valid_1),
    .out_ready (up_ready_1)
  );

  // Lane 0 is port a, so its words carry source id 0
  axis_frame_mux mux_i (
    .clk       (clk),
    .rst       (rst),
    .a_beat    (up_beat_0),
    .a_valid   (up_valid_0),
    .a_ready   (up_ready_0),
    .b_beat    (up_beat_1),
    .b_valid   (up_valid_1),
    .b_ready   (up_ready_1),
    .out_beat  (out_beat),
    .out_src   (out_src),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* axis_frame_mux.sv */
`default_nettype none

module axis_frame_mux import axis_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire wide_beat_t a_beat,
  input  wire logic       a_valid,
  output logic            a_ready,
  input  wire wide_beat_t b_beat,
  input  wire logic       b_valid,
  output logic            b_ready,
  output wide_beat_t      out_beat,
  output lane_id_t        out_src,
  output logic            out_valid,
  input  wire logic       out_ready
);

  lane_id_t grant;       // Lane that owns the output for the current frame
  lane_id_t last_grant;
  lane_id_t pick;
  logic     busy;

  wide_beat_t sel_beat;
  logic       valid_int;
  logic       take;

  wide_beat_t out_reg;
  lane_id_t   out_src_reg;
  logic       out_valid_reg;
  wide_beat_t skid_reg;
  lane_id_t   skid_src;
  logic       skid_valid;
  logic       out_ready_int;
  logic       ready_early;

  assign sel_beat  = grant ? b_beat : a_beat;
  assign valid_int = busy && (grant ? b_valid : a_valid);
  assign take      = valid_int && out_ready_int;

  // Only the granted lane ever sees ready
  assign a_ready = busy && (grant == 1'b0) && out_ready_int;
  assign b_ready = busy && (grant == 1'b1) && out_ready_int;

  assign out_beat  = out_reg;
  assign out_src   = out_src_reg;
  assign out_valid = out_valid_reg;

  assign ready_early = out_ready || (!skid_valid && !out_valid_reg) ||
                       (!skid_valid && !valid_int);

  // Round robin when both lanes wait, otherwise whichever one has data
  always_comb begin
    if (a_valid && b_valid) begin
      pick = ~last_grant;
    end else if (b_valid) begin
      pick = 1'b1;
    end else begin
      pick = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      grant      <= 1'b0;
      last_grant <= 1'b1;  // So lane 0 wins the first tie
    end else if (!busy) begin
      if (a_valid || b_valid) begin
        busy       <= 1'b1;
        grant      <= pick;
        last_grant <= pick;
      end
    end else if (take && sel_beat.last) begin
      busy <= 1'b0;  // Frame fully taken in
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_reg <= 1'b0;
      skid_valid    <= 1'b0;
      out_ready_int <= 1'b0;
    end else begin
      out_ready_int <= ready_early;
      if (out_ready_int) begin
        if (out_ready || !out_valid_reg) begin
          out_valid_reg <= valid_int;
        end else begin
          skid_valid <= valid_int;
        end
      end else if (out_ready) begin
        out_valid_reg <= skid_valid;
        skid_valid    <= 1'b0;
      end
    end
  end

  // Lane tag travels with its word through both registers
  always_ff @(posedge clk) begin
    if (out_ready_int) begin
      if (out_ready || !out_valid_reg) begin
        out_reg     <= sel_beat;
        out_src_reg <= grant;
      end else begin
        skid_reg <= sel_beat;
        skid_src <= grant;
      end
    end else if (out_ready) begin
      out_reg     <= skid_reg;
      out_src_reg <= skid_src;
    end
  end

endmodule

`default_nettype wire

/* axis_upsizer.sv */
`default_nettype none

module axis_upsizer import axis_pkg::*; (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire narrow_beat_t in_beat,
  input  wire logic         in_valid,
  output logic              in_ready,
  output wide_beat_t        out_beat,
  output logic              out_valid,
  input  wire logic         out_ready
);

  localparam int CNT_W = $clog2(WORD_BYTES);

  upsizer_state_t state;
  upsizer_state_t state_next;

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] cnt_next;

  wide_beat_t acc;       // Word being filled or held for the output stage
  wide_beat_t acc_next;

  logic in_ready_reg;
  logic in_ready_next;
  logic accept;

  // Output stage with one skid word
  wide_beat_t out_reg;
  logic       out_valid_reg;
  wide_beat_t skid_reg;
  logic       skid_valid;
  logic       valid_int;
  logic       out_ready_int;
  logic       ready_early;

  assign in_ready  = in_ready_reg;
  assign accept    = in_valid && in_ready_reg;
  assign valid_int = (state == send_st);

  assign out_beat  = out_reg;
  assign out_valid = out_valid_reg;

  // High when the output stage can take a word on the next cycle
  assign ready_early = out_ready || (!skid_valid && !out_valid_reg) ||
                       (!skid_valid && !valid_int);

  // Places one byte into the word at position idx, a zero index starts a fresh word
  function automatic wide_beat_t add_byte(
    input wide_beat_t       word,
    input logic [CNT_W-1:0] idx,
    input narrow_beat_t     beat
  );
    wide_beat_t w;
    w = (idx == '0) ? '0 : word;
    w.data[idx*$bits(byte_t) +: $bits(byte_t)] = beat.data;
    w.keep[idx] = 1'b1;
    w.last = beat.last;
    w.user = w.user | beat.user;  // Sticky across the word
    return w;
  endfunction

  always_comb begin
    state_next    = state;
    cnt_next      = cnt;
    acc_next      = acc;
    in_ready_next = 1'b0;

    case (state)
      fill_st: begin
        in_ready_next = 1'b1;
        if (accept) begin
          acc_next = add_byte(acc, cnt, in_beat);
          cnt_next = cnt + 1'b1;
          if (in_beat.last || cnt == CNT_W'(WORD_BYTES - 1)) begin
            // Word is closed, only take more bytes if it can leave next cycle
            state_next    = send_st;
            cnt_next      = '0;
            in_ready_next = ready_early;
          end
        end
      end

      send_st: begin
        in_ready_next = ready_early;
        if (out_ready_int) begin
          if (accept) begin
            // The held word leaves while the next word starts
            acc_next = add_byte(acc, '0, in_beat);
            if (in_beat.last) begin
              cnt_next = '0;
            end else begin
              cnt_next      = CNT_W'(1);
              state_next    = fill_st;
              in_ready_next = 1'b1;
            end
          end else begin
            state_next    = fill_st;
            in_ready_next = 1'b1;
          end
        end
      end

      default: begin
        state_next = fill_st;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= fill_st;
      cnt          <= '0;
      in_ready_reg <= 1'b0;
    end else begin
      state        <= state_next;
      cnt          <= cnt_next;
      in_ready_reg <= in_ready_next;
    end
  end

  always_ff @(posedge clk) begin
    acc <= acc_next;
  end

  // Registered output with skid word
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_reg <= 1'b0;
      skid_valid    <= 1'b0;
      out_ready_int <= 1'b0;
    end else begin
      out_ready_int <= ready_early;
      if (out_ready_int) begin
        if (out_ready || !out_valid_reg) begin
          out_valid_reg <= valid_int;
        end else begin
          skid_valid <= valid_int;  // Output busy, park the word
        end
      end else if (out_ready) begin
        out_valid_reg <= skid_valid;
        skid_valid    <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_ready_int) begin
      if (out_ready || !out_valid_reg) begin
        out_reg <= acc;
      end else begin
        skid_reg <= acc;
      end
    end else if (out_ready) begin
      out_reg <= skid_reg;
    end
  end

endmodule

`default_nettype wire

/* axis_pkg.sv */
`default_nettype none

package axis_pkg;

  // Bytes per output word of the upsizer
  localparam int WORD_BYTES = 4;

  // One byte of a narrow lane
  typedef logic [7:0] byte_t;

  // One output word, byte 0 in the low bits
  typedef logic [8*WORD_BYTES-1:0] word_t;

  // Per-byte valid flags, bit i covers byte i of the word
  typedef logic [WORD_BYTES-1:0] keep_t;

  // Source lane tag on the merged stream
  typedef logic [0:0] lane_id_t;

  // Narrow lane beat
  typedef struct packed {
    byte_t data;
    logic  last;  // End of frame
    logic  user;  // Error flag
  } narrow_beat_t;

  // Wide beat after the upsizer and on the merged output
  typedef struct packed {
    word_t data;
    keep_t keep;
    logic  last;
    logic  user;
  } wide_beat_t;

  // Upsizer fill machine
  typedef enum logic {
    fill_st,  // Collecting bytes into the word register
    send_st   // Closed word waiting to enter the output stage
  } upsizer_state_t;

endpackage

`default_nettype wire
